// ==== build.f ====
verilog/mips_cpu_pkg.sv
verilog/mips_cpu_ctrl_if.sv
verilog/mips_cpu_control.sv
verilog/mips_cpu_register_file.sv
verilog/mips_cpu_alu.sv
verilog/mips_cpu_pc_update.sv
verilog/mips_cpu_harvard.sv
tests/tb_clock.sv
tests/mips_cpu_harvard_tb.sv

// ==== tests/mips_cpu_harvard_tb.sv ====
`timescale 1ns/10ps

module mips_cpu_harvard_tb;
	import mips_cpu_pkg::*;

	logic clk;
	logic reset;
	logic clk_enable;
	logic active;
	word_t register_v0;
	word_t instr_address;
	word_t instr_readdata;
	word_t data_address;
	logic data_write;
	logic data_read;
	word_t data_writedata;
	word_t data_readdata;

	word_t imem [word_t]; // Sparse program store keyed by word address
	word_t dmem [0:1023];

	string test_name;
	int passes;
	int budget;
	int tests_run = 0;
	word_t exp_v0;
	word_t init_addr [$];
	word_t init_value [$];
	word_t exp_addr [$];
	word_t exp_value [$];

	tb_clock clock_i(
		.clk(clk)
	);

	mips_cpu_harvard dut_i(
		.clk(clk),
		.reset(reset),
		.active(active),
		.register_v0(register_v0),
		.clk_enable(clk_enable),
		.instr_address(instr_address),
		.instr_readdata(instr_readdata),
		.data_address(data_address),
		.data_write(data_write),
		.data_read(data_read),
		.data_writedata(data_writedata),
		.data_readdata(data_readdata)
	);

	// The core expects instruction words with their bytes reversed
	function automatic word_t fetch_swapped(input word_t addr);
		word_t raw;
		raw = imem.exists(addr >> 2) ? imem[addr >> 2] : '0;
		return {raw[7:0], raw[15:8], raw[23:16], raw[31:24]};
	endfunction

	function automatic logic [5:0] fetched_opcode();
		word_t key;
		key = instr_address >> 2;
		return imem.exists(key) ? imem[key][31:26] : 6'h00;
	endfunction

	assign instr_readdata = fetch_swapped(instr_address);
	assign data_readdata = dmem[data_address[11:2]];

	always @(posedge clk) begin
		if (data_write && clk_enable) begin
			dmem[data_address[11:2]] <= data_writedata;
		end
	end

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			stop_run($sformatf("mismatch %s: expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_run($sformatf("mismatch %s: expected %b actual %b", name, expected, actual));
		end
	endtask

	task automatic require_fields(input int got, input int wanted);
		if (got != wanted) begin
			stop_run($sformatf("golden file record is malformed in test '%s'", test_name));
		end
	endtask

	task automatic load_data_memory();
		for (int i = 0; i < 1024; i++) begin
			dmem[i] = 32'hC0DE_0000 | (i << 2); // Background tracks the address
		end
		foreach (init_addr[k]) begin
			dmem[init_addr[k][11:2]] = init_value[k];
		end
	endtask

	task automatic reset_dut(input string label);
		int waited;
		@(posedge clk);
		reset <= 1'b1;
		clk_enable <= 1'b1;
		repeat (7) @(posedge clk);
		@(negedge clk);
		check_word({label, " reset pc"}, RESET_VECTOR, instr_address);
		check_flag({label, " reset active"}, 1'b0, active);
		check_word({label, " reset v0"}, '0, register_v0);
		@(posedge clk);
		reset <= 1'b0;
		waited = 0;
		while (!active) begin
			@(negedge clk);
			waited++;
			if (!active && waited >= 4) begin
				stop_run($sformatf("active did not rise after reset in test %s", label));
			end
		end
	endtask

	task automatic run_until_halt(input string label, input logic gated);
		int cycles;
		int limit;
		logic [5:0] opcode;
		cycles = 0;
		limit = gated ? budget * 4 : budget; // Gating stalls about half the edges
		while (active) begin
			@(posedge clk);
			if (gated) begin
				clk_enable <= ($urandom_range(1, 0) == 1);
			end else begin
				clk_enable <= 1'b1;
			end
			@(negedge clk);
			cycles++;
			opcode = fetched_opcode(); // Memory strobes follow the fetched opcode while running
			check_flag({label, " data_read"}, active && (opcode == OP_LW), data_read);
			check_flag({label, " data_write"}, active && (opcode == OP_SW), data_write);
			if (active && cycles >= limit) begin
				stop_run($sformatf("timeout: test %s did not halt within %0d cycles",
					label, limit));
			end
		end
		check_word({label, " halt pc"}, '0, instr_address);
	endtask

	task automatic idle_after_halt(input string label);
		repeat (20) begin
			@(posedge clk);
			clk_enable <= 1'b1;
			@(negedge clk);
			check_flag({label, " idle active"}, 1'b0, active);
			check_flag({label, " idle data_write"}, 1'b0, data_write);
		end
	endtask

	task automatic run_test();
		string label;
		imem[0] = 32'hAC02_0000; // A store of v0 waits at the halt address
		for (int pass = 0; pass < passes; pass++) begin
			label = (pass == 0) ? test_name : $sformatf("%s gated", test_name);
			load_data_memory();
			reset_dut(label);
			run_until_halt(label, pass > 0);
			idle_after_halt(label);
			check_word({label, " v0"}, exp_v0, register_v0);
			foreach (exp_addr[i]) begin
				check_word($sformatf("%s mem[%h]", label, exp_addr[i]), exp_value[i],
					dmem[exp_addr[i][11:2]]);
			end
		end
		tests_run++;
	endtask

	initial begin
		int fd;
		int code;
		int count;
		string tok;
		string line;
		word_t addr;
		word_t value;
		reset = 1'b1;
		clk_enable = 1'b0;
		void'($urandom(47255));
		fd = $fopen("tests/program_golden.txt", "r");
		if (fd == 0) begin
			stop_run("could not open tests/program_golden.txt");
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			case (tok)
				"#": code = $fgets(line, fd);
				"test": begin
					code = $fscanf(fd, "%s %d", test_name, passes);
					require_fields(code, 2);
					imem.delete();
					init_addr.delete();
					init_value.delete();
					exp_addr.delete();
					exp_value.delete();
				end
				"prog": begin
					code = $fscanf(fd, "%h %d", addr, count);
					require_fields(code, 2);
					for (int n = 0; n < count; n++) begin
						code = $fscanf(fd, "%h", value);
						require_fields(code, 1);
						imem[(addr >> 2) + n] = value;
					end
				end
				"data": begin
					code = $fscanf(fd, "%h %h", addr, value);
					require_fields(code, 2);
					init_addr.push_back(addr);
					init_value.push_back(value);
				end
				"expect": begin
					code = $fscanf(fd, "%h %h", addr, value);
					require_fields(code, 2);
					exp_addr.push_back(addr);
					exp_value.push_back(value);
				end
				"budget": begin
					code = $fscanf(fd, "%d", budget);
					require_fields(code, 1);
				end
				"v0": begin
					code = $fscanf(fd, "%h", exp_v0);
					require_fields(code, 1);
				end
				"end": run_test();
				default: stop_run($sformatf("unknown record '%s' in golden file", tok));
			endcase
		end
		$fclose(fd);
		if (tests_run == 0) begin
			stop_run("no test records found in tests/program_golden.txt");
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== tests/program_golden.txt ====
# Records: test <name> <passes>, prog <addr> <count> then the words, data <addr> <word>,
# budget <cycles>, v0 <word>, expect <addr> <word>, end. A second pass gates clk_enable.
test alu 2
prog bfc00000 29
3c081234 35088765 2409fffd 240a7f0f
010a5821 01496023 01686824 01aa7025
01cc1026 0009782a 0009802b 2931fffe
2d32ffff 00108100 00118a00 00129300
01f07821 01f17821 01f27821 00099f02
0009a043 3135f0f0 393600ff 004f1021
00531026 00541023 00551021 00561026
00000008
budget 40
v0 edcafd76
end
# Loads, stores with a negative offset, v0 from a stored sum
test mem 1
prog bfc00000 9
24081000 8d090000 8d0a0004 012a5821
ad0b0008 250c0010 ad89fffc 8d020008
00000008
data 00001000 11223344
data 00001004 a5a5a5a5
budget 20
v0 b6c7d8e9
expect 00001000 11223344
expect 00001004 a5a5a5a5
expect 00001008 b6c7d8e9
expect 0000100c 11223344
end
# Branches, JAL and JR through r31, a write to r0, J over a skipped word
test flow 1
prog bfc00000 22
24080005 24090005 24020001 11090001
24420100 15090001 24420002 11000001
24420004 15000001 24420008 0ff00010
24000055 00401021 0bf00014 24420040
24420010 03e05021 03e00008 24420020
004a1026 00000008
budget 30
v0 bfc00027
end

// ==== tests/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock(
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk; // Half of the 8 ns period
		end
	end

endmodule

// ==== verilog/mips_cpu_alu.sv ====
`timescale 1ns/10ps

module mips_cpu_alu(
	input mips_cpu_pkg::word_t a,
	input mips_cpu_pkg::word_t b,
	input mips_cpu_pkg::alu_op_t op,
	output mips_cpu_pkg::word_t result,
	output logic equal
);
	import mips_cpu_pkg::*;

	logic [4:0] shamt;
	logic less_signed;
	logic less_unsigned;

	assign shamt = a[4:0]; // Shift amount rides on the A operand
	assign less_signed = $signed(a) < $signed(b);
	assign less_unsigned = a < b;
	assign equal = (a == b); // Used by BEQ and BNE whatever op says

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_NOR: result = ~(a | b);
			ALU_SLT: result = {31'b0, less_signed};
			ALU_SLTU: result = {31'b0, less_unsigned};
			ALU_SLL: result = b << shamt;
			ALU_SRL: result = b >> shamt;
			ALU_SRA: result = $signed(b) >>> shamt;
			ALU_LUI: result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

endmodule

// ==== verilog/mips_cpu_control.sv ====
`timescale 1ns/10ps

module mips_cpu_control(
	input mips_cpu_pkg::word_t instruction,
	mips_cpu_ctrl_if.decoder ctrl
);
	import mips_cpu_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic zero_ext;

	assign opcode = instruction[31:26];
	assign funct = instruction[5:0];
	assign zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
	assign ctrl.imm = zero_ext ? {16'h0000, instruction[15:0]}
		: {{16{instruction[15]}}, instruction[15:0]};

	always_comb begin
		ctrl.reg_dst = 1'b0;
		ctrl.alu_src_imm = 1'b0;
		ctrl.shift_by_sa = 1'b0;
		ctrl.mem_to_reg = 1'b0;
		ctrl.reg_write = 1'b0;
		ctrl.mem_read = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.branch_eq = 1'b0;
		ctrl.branch_ne = 1'b0;
		ctrl.jump = 1'b0;
		ctrl.jump_reg = 1'b0;
		ctrl.link = 1'b0;
		ctrl.alu_op = ALU_ADD;
		// Immediate forms all write rt from the ALU
		if (opcode[5:3] == 3'b001) begin
			ctrl.alu_src_imm = 1'b1;
			ctrl.reg_write = 1'b1;
		end
		case (opcode)
			OP_SPECIAL: begin
				ctrl.reg_dst = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.shift_by_sa = (funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA);
				case (funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND: ctrl.alu_op = ALU_AND;
					FN_OR: ctrl.alu_op = ALU_OR;
					FN_XOR: ctrl.alu_op = ALU_XOR;
					FN_SLT: ctrl.alu_op = ALU_SLT;
					FN_SLTU: ctrl.alu_op = ALU_SLTU;
					FN_SLL: ctrl.alu_op = ALU_SLL;
					FN_SRL: ctrl.alu_op = ALU_SRL;
					FN_SRA: ctrl.alu_op = ALU_SRA;
					FN_JR: begin
						ctrl.reg_write = 1'b0;
						ctrl.jump_reg = 1'b1;
					end
					default: ctrl.reg_write = 1'b0; // Unsupported function is a no-op
				endcase
			end
			OP_SLTI: ctrl.alu_op = ALU_SLT;
			OP_SLTIU: ctrl.alu_op = ALU_SLTU;
			OP_ANDI: ctrl.alu_op = ALU_AND;
			OP_ORI: ctrl.alu_op = ALU_OR;
			OP_XORI: ctrl.alu_op = ALU_XOR;
			OP_LUI: ctrl.alu_op = ALU_LUI;
			OP_LW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.mem_read = 1'b1;
			end
			OP_SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			OP_BEQ: ctrl.branch_eq = 1'b1;
			OP_BNE: ctrl.branch_ne = 1'b1;
			OP_J: ctrl.jump = 1'b1;
			OP_JAL: begin
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_ADDIU: ctrl.alu_op = ALU_ADD;
			default: begin
				ctrl.alu_src_imm = 1'b0;
				ctrl.reg_write = 1'b0; // Unknown opcode in the immediate group
			end
		endcase
	end

endmodule

// ==== verilog/mips_cpu_ctrl_if.sv ====
`timescale 1ns/10ps

interface mips_cpu_ctrl_if;
	import mips_cpu_pkg::*;

	logic reg_dst; // Write to rd instead of rt
	logic alu_src_imm;
	logic shift_by_sa; // ALU A operand takes the shamt field
	logic mem_to_reg;
	logic reg_write;
	logic mem_read;
	logic mem_write;
	logic branch_eq;
	logic branch_ne;
	logic jump;
	logic jump_reg;
	logic link;
	alu_op_t alu_op;
	word_t imm;

	modport decoder(
		output reg_dst, alu_src_imm, shift_by_sa, mem_to_reg, reg_write, mem_read,
		mem_write, branch_eq, branch_ne, jump, jump_reg, link, alu_op, imm
	);

	modport datapath(
		input reg_dst, alu_src_imm, shift_by_sa, mem_to_reg, reg_write, mem_read,
		mem_write, branch_eq, branch_ne, jump, jump_reg, link, alu_op, imm
	);

endinterface

// ==== verilog/mips_cpu_harvard.sv ====
`timescale 1ns/10ps

module mips_cpu_harvard(
	input logic clk,
	input logic reset,
	output logic active,
	output mips_cpu_pkg::word_t register_v0,

	input logic clk_enable,

	output mips_cpu_pkg::word_t instr_address,
	input mips_cpu_pkg::word_t instr_readdata,

	output mips_cpu_pkg::word_t data_address,
	output logic data_write,
	output logic data_read,
	output mips_cpu_pkg::word_t data_writedata,
	input mips_cpu_pkg::word_t data_readdata
);
	import mips_cpu_pkg::*;

	word_t instruction;
	word_t pc;
	word_t link_value;
	word_t reg_a;
	word_t reg_b;
	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	word_t write_data;
	reg_addr_t addr_rs;
	reg_addr_t addr_rt;
	reg_addr_t addr_rd;
	reg_addr_t write_addr;
	logic equal;
	logic reg_write_en;

	mips_cpu_ctrl_if ctrl();

	// Instruction memory delivers words byte-reversed
	assign instruction = {instr_readdata[7:0], instr_readdata[15:8],
		instr_readdata[23:16], instr_readdata[31:24]};
	assign instr_address = pc;

	assign addr_rs = instruction[25:21];
	assign addr_rt = instruction[20:16];
	assign addr_rd = instruction[15:11];

	always_comb begin
		if (ctrl.link) begin
			write_addr = REG_RA;
			write_data = link_value;
		end else begin
			write_addr = ctrl.reg_dst ? addr_rd : addr_rt;
			write_data = ctrl.mem_to_reg ? data_readdata : alu_result;
		end
	end

	assign alu_a = ctrl.shift_by_sa ? {27'b0, instruction[10:6]} : reg_a;
	assign alu_b = ctrl.alu_src_imm ? ctrl.imm : reg_b;

	assign data_address = alu_result;
	assign data_writedata = reg_b;
	assign data_read = ctrl.mem_read && active;
	assign data_write = ctrl.mem_write && active; // Memory side gates this with clk_enable
	assign reg_write_en = ctrl.reg_write && active && clk_enable;

	mips_cpu_control control_i(
		.instruction(instruction),
		.ctrl(ctrl)
	);

	mips_cpu_register_file regfile_i(
		.clk(clk),
		.reset(reset),
		.write_enable(reg_write_en),
		.read_addr_a(addr_rs),
		.read_addr_b(addr_rt),
		.write_addr(write_addr),
		.write_data(write_data),
		.read_data_a(reg_a),
		.read_data_b(reg_b),
		.v0(register_v0)
	);

	mips_cpu_alu alu_i(
		.a(alu_a),
		.b(alu_b),
		.op(ctrl.alu_op),
		.result(alu_result),
		.equal(equal)
	);

	mips_cpu_pc_update pc_update_i(
		.clk(clk),
		.reset(reset),
		.clk_enable(clk_enable),
		.ctrl(ctrl),
		.instruction(instruction),
		.rs_value(reg_a),
		.equal(equal),
		.pc(pc),
		.link_value(link_value),
		.active(active)
	);

endmodule

// ==== verilog/mips_cpu_pc_update.sv ====
`timescale 1ns/10ps

module mips_cpu_pc_update(
	input logic clk,
	input logic reset,
	input logic clk_enable,
	mips_cpu_ctrl_if.datapath ctrl,
	input mips_cpu_pkg::word_t instruction,
	input mips_cpu_pkg::word_t rs_value,
	input logic equal,
	output mips_cpu_pkg::word_t pc,
	output mips_cpu_pkg::word_t link_value,
	output logic active
);
	import mips_cpu_pkg::*;

	word_t pc_plus4;
	word_t branch_target;
	word_t jump_target;
	word_t next_pc;
	logic taken;
	logic started; // Set once the run after reset has begun

	assign pc_plus4 = pc + 32'd4;
	assign link_value = pc_plus4; // No delay slot so the return point is the next word
	assign branch_target = pc_plus4 + {ctrl.imm[29:0], 2'b00};
	assign jump_target = {pc_plus4[31:28], instruction[25:0], 2'b00};
	assign taken = (ctrl.branch_eq && equal) || (ctrl.branch_ne && !equal);

	always_comb begin
		if (ctrl.jump_reg) begin
			next_pc = rs_value;
		end else if (ctrl.jump) begin
			next_pc = jump_target;
		end else if (taken) begin
			next_pc = branch_target;
		end else begin
			next_pc = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_VECTOR;
			active <= 1'b0;
			started <= 1'b0;
		end else if (!started) begin
			active <= 1'b1;
			started <= 1'b1;
		end else if (clk_enable && active) begin
			pc <= next_pc;
			if (next_pc == '0) begin
				active <= 1'b0; // Jump to address 0 halts the core
			end
		end
	end

endmodule

// ==== verilog/mips_cpu_pkg.sv ====
package mips_cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} alu_op_t;

	localparam word_t RESET_VECTOR = 32'hBFC0_0000;
	localparam reg_addr_t REG_V0 = 5'd2;
	localparam reg_addr_t REG_RA = 5'd31; // Link register for JAL

	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_JAL = 6'h03;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI = 6'h0A;
	localparam logic [5:0] OP_SLTIU = 6'h0B;
	localparam logic [5:0] OP_ANDI = 6'h0C;
	localparam logic [5:0] OP_ORI = 6'h0D;
	localparam logic [5:0] OP_XORI = 6'h0E;
	localparam logic [5:0] OP_LUI = 6'h0F;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2B;

	// Function field values under OP_SPECIAL
	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_SRL = 6'h02;
	localparam logic [5:0] FN_SRA = 6'h03;
	localparam logic [5:0] FN_JR = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2A;
	localparam logic [5:0] FN_SLTU = 6'h2B;

endpackage

// ==== verilog/mips_cpu_register_file.sv ====
`timescale 1ns/10ps

module mips_cpu_register_file(
	input logic clk,
	input logic reset,
	input logic write_enable,
	input mips_cpu_pkg::reg_addr_t read_addr_a,
	input mips_cpu_pkg::reg_addr_t read_addr_b,
	input mips_cpu_pkg::reg_addr_t write_addr,
	input mips_cpu_pkg::word_t write_data,
	output mips_cpu_pkg::word_t read_data_a,
	output mips_cpu_pkg::word_t read_data_b,
	output mips_cpu_pkg::word_t v0
);
	import mips_cpu_pkg::*;

	word_t regs [1:31]; // No storage behind register 0

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable && (write_addr != '0)) begin
			regs[write_addr] <= write_data;
		end
	end

	assign read_data_a = (read_addr_a == '0) ? '0 : regs[read_addr_a];
	assign read_data_b = (read_addr_b == '0) ? '0 : regs[read_addr_b];
	assign v0 = regs[REG_V0];

endmodule
